//--- design/csr_pkg.sv
// Register manager shared definitions
package csr_pkg;

    // ==============================
    // Address map and widths
    // ==============================

    // Byte address of the register region
    localparam logic [31:0] CSR_BASE_ADDR = 32'h100;
    // Number of 64-bit registers
    localparam int CSR_WORDS = 16;

    // Host address counts 4-byte units
    localparam int MMIO_ADDR_W = 16;
    localparam int TID_W = 9;
    localparam int CSR_DATA_W = 64;
    localparam int PT_BASE_W = 58;

    // Region bounds in 4-byte units, two units per register
    localparam logic [MMIO_ADDR_W-1:0] CSR_BASE_UNIT = MMIO_ADDR_W'(CSR_BASE_ADDR >> 2);
    localparam logic [MMIO_ADDR_W-1:0] CSR_LAST_UNIT = CSR_BASE_UNIT + MMIO_ADDR_W'(CSR_WORDS * 2);

    // Statistics accumulators
    localparam int STAT_CNT_W = 16;
    localparam int NUM_STATS = 3;
    localparam int FLUSH_PERIOD_LOG2 = 10;

    // Outstanding host reads
    localparam int REQ_QUEUE_DEPTH = 8;

    typedef logic [$clog2(CSR_WORDS)-1:0] t_csr_idx;
    typedef logic [TID_W-1:0] t_tid;
    typedef logic [CSR_DATA_W-1:0] t_csr_data;
    typedef logic [STAT_CNT_W-1:0] t_stat_cnt;

    // Word indices
    localparam t_csr_idx IDX_DFH = 4'd0;
    localparam t_csr_idx IDX_UID_L = 4'd1;
    localparam t_csr_idx IDX_UID_H = 4'd2;
    localparam t_csr_idx IDX_MODE = 4'd3;
    localparam t_csr_idx IDX_STAT_HIT = 4'd4;
    localparam t_csr_idx IDX_STAT_MISS = 4'd5;
    localparam t_csr_idx IDX_STAT_WALK = 4'd6;
    localparam t_csr_idx IDX_PT_BASE = 4'd8;

    // ==============================
    // Feature header
    // ==============================

    // Type, end of list, next offset, instance ID
    localparam t_csr_data FEATURE_DFH = {4'h2, 19'h0, 1'b1, 24'h80, 4'h0, 12'h1};
    localparam logic [127:0] FEATURE_UID = 128'h3f6d91a2_c4b8_4e07_9a15_d2e60b7c5843;

    // Decoded host request kind
    typedef enum logic [1:0] {
        OP_NONE,
        OP_READ,
        OP_WRITE
    } t_mmio_op;

    // Statistics sequencer
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT,
        ST_WRITE
    } t_stat_state;

endpackage

//--- design/mmio_decode.sv
// Host request decode
`timescale 1ns/1ps

module mmio_decode
    import csr_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   mmio_valid,
    input  logic                   mmio_write,
    input  logic [MMIO_ADDR_W-1:0] mmio_addr,
    input  t_tid                   mmio_tid,
    input  t_csr_data              mmio_data,
    input  logic                   rd_start,
    output logic                   queue_valid,
    output t_csr_idx               queue_idx,
    output t_tid                   queue_tid,
    output logic                   xlate_enable,
    output logic                   xlate_inval,
    output logic [PT_BASE_W-1:0]   pt_base,
    output logic                   pt_base_valid
);

    // Stage 1 holds the raw request
    logic                   req_valid;
    logic                   req_write;
    logic [MMIO_ADDR_W-1:0] req_addr;
    t_tid                   req_tid;
    t_csr_data              req_data;

    // Stage 2 holds the classified request
    t_mmio_op               req_op;
    t_csr_idx               op_idx;
    t_tid                   op_tid;
    t_csr_data              op_data;

    logic [MMIO_ADDR_W-1:0] req_offset;
    logic                   in_range;

    // Read request queue
    t_csr_idx                         q_idx [REQ_QUEUE_DEPTH];
    t_tid                             q_tid [REQ_QUEUE_DEPTH];
    logic [$clog2(REQ_QUEUE_DEPTH)-1:0] wr_ptr;
    logic [$clog2(REQ_QUEUE_DEPTH)-1:0] rd_ptr;
    logic [$clog2(REQ_QUEUE_DEPTH):0]   q_count;
    logic                             full;
    logic                             push;
    logic                             pop;

    always_ff @(posedge clk)
    begin
        if (reset)
            req_valid <= 1'b0;
        else
            req_valid <= mmio_valid;
        req_write <= mmio_write;
        req_addr <= mmio_addr;
        req_tid <= mmio_tid;
        req_data <= mmio_data;
    end

    // Offset from the region base, still in 4-byte units
    assign req_offset = req_addr - CSR_BASE_UNIT;
    assign in_range = (req_addr >= CSR_BASE_UNIT) && (req_addr < CSR_LAST_UNIT);

    always_ff @(posedge clk)
    begin
        if (reset)
            req_op <= OP_NONE;
        else if (req_valid && in_range)
            req_op <= req_write ? OP_WRITE : OP_READ;
        else
            req_op <= OP_NONE;
        // Two 4-byte units per 64-bit word
        op_idx <= req_offset[1 +: $bits(t_csr_idx)];
        op_tid <= req_tid;
        op_data <= req_data;
    end

    // ==============================
    // Control writes
    // ==============================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            xlate_enable <= 1'b0;
            xlate_inval <= 1'b0;
            pt_base_valid <= 1'b0;
        end
        else
        begin
            // Invalidate lasts a single cycle
            xlate_inval <= 1'b0;
            if (req_op == OP_WRITE && op_idx == IDX_MODE)
            begin
                xlate_enable <= op_data[0];
                xlate_inval <= op_data[1];
            end
            if (req_op == OP_WRITE && op_idx == IDX_PT_BASE)
                pt_base_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (req_op == OP_WRITE && op_idx == IDX_PT_BASE)
            pt_base <= op_data[PT_BASE_W-1:0];
    end

    // ==============================
    // Read queue
    // ==============================

    // Reads arriving when full are lost
    assign full = (q_count == ($clog2(REQ_QUEUE_DEPTH) + 1)'(REQ_QUEUE_DEPTH));
    assign push = (req_op == OP_READ) && !full;
    assign pop = rd_start && queue_valid;

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            q_idx[wr_ptr] <= op_idx;
            q_tid[wr_ptr] <= op_tid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            q_count <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            q_count <= q_count + push - pop;
        end
    end

    assign queue_valid = (q_count != '0);
    assign queue_idx = q_idx[rd_ptr];
    assign queue_tid = q_tid[rd_ptr];

endmodule

//--- design/event_accum.sv
// Event accumulators and flush timer
`timescale 1ns/1ps

module event_accum
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      event_hit,
    input  logic      event_miss,
    input  logic      event_walk_busy,
    input  logic      flush_ready,
    output logic      flush,
    output t_stat_cnt cnt_hit,
    output t_stat_cnt cnt_miss,
    output t_stat_cnt cnt_walk
);

    // Interval timer saturates once the period has elapsed
    logic [FLUSH_PERIOD_LOG2:0] interval;
    logic [NUM_STATS-1:0]       ev_in;
    logic [NUM_STATS-1:0]       ev_q;
    t_stat_cnt                  acc [NUM_STATS];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            interval <= '0;
            flush <= 1'b0;
        end
        else
        begin
            // Single-cycle strobe, the sequencer drops ready behind it
            flush <= interval[FLUSH_PERIOD_LOG2] && flush_ready && !flush;
            if (flush)
                interval <= '0;
            else if (!interval[FLUSH_PERIOD_LOG2])
                interval <= interval + 1'b1;
        end
    end

    // Order matches the statistics word order
    assign ev_in = {event_walk_busy, event_miss, event_hit};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ev_q <= '0;
            for (int s = 0; s < NUM_STATS; s++)
                acc[s] <= '0;
        end
        else
        begin
            ev_q <= ev_in;
            // Flushed counts restart from the event just registered
            for (int s = 0; s < NUM_STATS; s++)
                acc[s] <= (flush ? t_stat_cnt'(0) : acc[s]) + t_stat_cnt'(ev_q[s]);
        end
    end

    assign cnt_hit = acc[0];
    assign cnt_miss = acc[1];
    assign cnt_walk = acc[2];

endmodule

//--- design/csr_access.sv
// Store port arbitration and statistics update
`timescale 1ns/1ps

module csr_access
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      queue_valid,
    input  t_csr_idx  queue_idx,
    input  t_tid      queue_tid,
    input  logic      busy,
    input  logic      store_ready,
    input  logic      rd_data_valid,
    input  t_csr_data rd_data,
    input  logic      flush,
    input  t_stat_cnt cnt_hit,
    input  t_stat_cnt cnt_miss,
    input  t_stat_cnt cnt_walk,
    output logic      rd_start,
    output t_tid      rd_tid,
    output logic      flush_ready,
    output logic      rd_en,
    output t_csr_idx  rd_idx,
    output logic      wr_en,
    output t_csr_idx  wr_idx,
    output t_csr_data wr_data
);

    t_stat_state                  state;
    logic [$clog2(NUM_STATS)-1:0] sel;
    t_stat_cnt                    cnt_q [NUM_STATS];
    t_csr_data                    sum_q;
    t_csr_idx                     stat_idx;
    logic                         stat_rd;
    logic                         last;
    // Marks own reads along the two-cycle store latency
    logic [1:0]                   own_pipe;
    logic                         own_valid;

    // Host reads win the port over the sequencer
    assign rd_start = queue_valid && !busy && store_ready && (state != ST_WAIT);
    assign rd_tid = queue_tid;

    assign stat_idx = IDX_STAT_HIT + t_csr_idx'(sel);
    assign stat_rd = (state == ST_REQ) && store_ready && !rd_start && (cnt_q[sel] != '0);
    assign last = (sel == ($clog2(NUM_STATS))'(NUM_STATS - 1));
    assign own_valid = rd_data_valid && own_pipe[1];

    assign rd_en = rd_start || stat_rd;
    assign rd_idx = rd_start ? queue_idx : stat_idx;
    assign wr_en = (state == ST_WRITE);
    assign wr_idx = stat_idx;
    assign wr_data = sum_q;
    assign flush_ready = (state == ST_IDLE);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= ST_IDLE;
            sel <= '0;
            own_pipe <= '0;
        end
        else
        begin
            own_pipe <= {own_pipe[0], stat_rd};
            case (state)
                ST_IDLE:
                begin
                    if (flush)
                    begin
                        state <= ST_REQ;
                        sel <= '0;
                    end
                end
                ST_REQ:
                begin
                    // Zero counts leave their word untouched
                    if (cnt_q[sel] == '0)
                    begin
                        state <= last ? ST_IDLE : ST_REQ;
                        sel <= sel + 1'b1;
                    end
                    else if (stat_rd)
                        state <= ST_WAIT;
                end
                ST_WAIT:
                begin
                    if (own_valid)
                        state <= ST_WRITE;
                end
                default:
                begin
                    // Write-back of the sum happens in this cycle
                    state <= last ? ST_IDLE : ST_REQ;
                    sel <= sel + 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == ST_IDLE && flush)
        begin
            cnt_q[0] <= cnt_hit;
            cnt_q[1] <= cnt_miss;
            cnt_q[2] <= cnt_walk;
        end
        if (own_valid)
            sum_q <= rd_data + t_csr_data'(cnt_q[sel]);
    end

endmodule

//--- design/csr_store.sv
// Register store with reset initialization
`timescale 1ns/1ps

module csr_store
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      rd_en,
    input  t_csr_idx  rd_idx,
    input  logic      wr_en,
    input  t_csr_idx  wr_idx,
    input  t_csr_data wr_data,
    output t_csr_data rd_data,
    output logic      rd_data_valid,
    output logic      store_ready
);

    t_csr_data mem [CSR_WORDS];
    t_csr_data ram_q;
    logic      rd_q;

    // Initialization walks every word once
    t_csr_idx  init_idx;
    logic      init_done;
    t_csr_data init_val;

    logic      wen;
    t_csr_idx  waddr;
    t_csr_data wdata;

    // ==============================
    // Initial contents
    // ==============================

    always_comb
    begin
        case (init_idx)
            IDX_DFH:   init_val = FEATURE_DFH;
            IDX_UID_L: init_val = FEATURE_UID[63:0];
            IDX_UID_H: init_val = FEATURE_UID[127:64];
            default:   init_val = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            init_idx <= '0;
            init_done <= 1'b0;
        end
        else if (!init_done)
        begin
            init_idx <= init_idx + 1'b1;
            if (init_idx == t_csr_idx'(CSR_WORDS - 1))
                init_done <= 1'b1;
        end
    end

    assign store_ready = init_done;

    // Init sequence owns the write port until done
    assign wen = (!init_done && !reset) || wr_en;
    assign waddr = init_done ? wr_idx : init_idx;
    assign wdata = init_done ? wr_data : init_val;

    // ==============================
    // RAM with output register
    // ==============================

    always_ff @(posedge clk)
    begin
        if (wen)
            mem[waddr] <= wdata;
        if (rd_en)
            ram_q <= mem[rd_idx];
        rd_data <= ram_q;
    end

    // Valid tracks the two read stages
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_q <= 1'b0;
            rd_data_valid <= 1'b0;
        end
        else
        begin
            rd_q <= rd_en;
            rd_data_valid <= rd_q;
        end
    end

endmodule

//--- design/read_response.sv
// Local read response and merge
`timescale 1ns/1ps

module read_response
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      rd_start,
    input  t_tid      rd_tid,
    input  logic      rd_data_valid,
    input  t_csr_data rd_data,
    input  logic      afu_rsp_valid,
    input  t_tid      afu_rsp_tid,
    input  t_csr_data afu_rsp_data,
    output logic      busy,
    output logic      rsp_valid,
    output t_tid      rsp_tid,
    output t_csr_data rsp_data
);

    // Host read in flight through the store, statistics pulses fall outside it
    logic [1:0] pend;
    logic       capture;
    logic       held;
    t_tid       held_tid;
    t_csr_data  held_data;
    logic       send_local;

    assign capture = rd_data_valid && pend[1];
    // Accelerator responses always go first
    assign send_local = held && !afu_rsp_valid;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pend <= '0;
            held <= 1'b0;
            busy <= 1'b0;
            rsp_valid <= 1'b0;
        end
        else
        begin
            pend <= {pend[0], rd_start};
            if (rd_start)
                busy <= 1'b1;
            else if (send_local)
                busy <= 1'b0;
            if (capture)
                held <= 1'b1;
            else if (send_local)
                held <= 1'b0;
            rsp_valid <= afu_rsp_valid || send_local;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_start)
            held_tid <= rd_tid;
        if (capture)
            held_data <= rd_data;
        rsp_tid <= afu_rsp_valid ? afu_rsp_tid : held_tid;
        rsp_data <= afu_rsp_valid ? afu_rsp_data : held_data;
    end

endmodule

//--- design/csr_manager.sv
// Register manager top level
`timescale 1ns/1ps

module csr_manager
    import csr_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    // Host requests
    input  logic                   mmio_valid,
    input  logic                   mmio_write,
    input  logic [MMIO_ADDR_W-1:0] mmio_addr,
    input  t_tid                   mmio_tid,
    input  t_csr_data              mmio_data,
    // Host responses
    output logic                   rsp_valid,
    output t_tid                   rsp_tid,
    output t_csr_data              rsp_data,
    // Accelerator responses
    input  logic                   afu_rsp_valid,
    input  t_tid                   afu_rsp_tid,
    input  t_csr_data              afu_rsp_data,
    // Translation unit events and controls
    input  logic                   event_hit,
    input  logic                   event_miss,
    input  logic                   event_walk_busy,
    output logic                   xlate_enable,
    output logic                   xlate_inval,
    output logic [PT_BASE_W-1:0]   pt_base,
    output logic                   pt_base_valid
);

    logic      queue_valid;
    t_csr_idx  queue_idx;
    t_tid      queue_tid;
    logic      rd_start;
    t_tid      rd_tid;
    logic      busy;
    logic      flush;
    logic      flush_ready;
    t_stat_cnt cnt_hit;
    t_stat_cnt cnt_miss;
    t_stat_cnt cnt_walk;
    logic      rd_en;
    t_csr_idx  rd_idx;
    logic      wr_en;
    t_csr_idx  wr_idx;
    t_csr_data wr_data;
    t_csr_data rd_data;
    logic      rd_data_valid;
    logic      store_ready;

    mmio_decode u_decode (
        .clk, .reset,
        .mmio_valid, .mmio_write, .mmio_addr, .mmio_tid, .mmio_data,
        .rd_start,
        .queue_valid, .queue_idx, .queue_tid,
        .xlate_enable, .xlate_inval, .pt_base, .pt_base_valid
    );

    event_accum u_accum (
        .clk, .reset,
        .event_hit, .event_miss, .event_walk_busy,
        .flush_ready,
        .flush, .cnt_hit, .cnt_miss, .cnt_walk
    );

    csr_access u_access (
        .clk, .reset,
        .queue_valid, .queue_idx, .queue_tid,
        .busy, .store_ready, .rd_data_valid, .rd_data,
        .flush, .cnt_hit, .cnt_miss, .cnt_walk,
        .rd_start, .rd_tid, .flush_ready,
        .rd_en, .rd_idx, .wr_en, .wr_idx, .wr_data
    );

    csr_store u_store (
        .clk, .reset,
        .rd_en, .rd_idx, .wr_en, .wr_idx, .wr_data,
        .rd_data, .rd_data_valid, .store_ready
    );

    read_response u_response (
        .clk, .reset,
        .rd_start, .rd_tid, .rd_data_valid, .rd_data,
        .afu_rsp_valid, .afu_rsp_tid, .afu_rsp_data,
        .busy, .rsp_valid, .rsp_tid, .rsp_data
    );

endmodule

//--- sim/csr_manager_assertions.sv
// Register manager protocol checks
`timescale 1ns/1ps

module csr_manager_assertions
    import csr_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     xlate_enable,
    input  logic     xlate_inval,
    input  logic     pt_base_valid,
    input  logic     rsp_valid,
    input  t_tid     rsp_tid,
    input  logic     afu_rsp_valid,
    input  t_tid     afu_rsp_tid,
    input  logic     flush,
    input  t_mmio_op req_op,
    input  logic     queue_full
);

    // Failures seen so far, polled by the testbench
    int fail_count = 0;

    // Outputs hold reset values on the cycle after a reset cycle
    reset_values: assert property (@(posedge clk)
        reset |=> !rsp_valid && !xlate_enable && !xlate_inval && !pt_base_valid && !flush)
    else
    begin
        $error("Outputs not low after reset");
        fail_count++;
    end

    // Invalidate is a single-cycle pulse
    inval_pulse: assert property (@(posedge clk) disable iff (reset)
        xlate_inval |=> !xlate_inval)
    else
    begin
        $error("xlate_inval high for more than one cycle");
        fail_count++;
    end

    // Host keeps at most eight reads in flight
    queue_limit: assert property (@(posedge clk) disable iff (reset)
        !(req_op == OP_READ && queue_full))
    else
    begin
        $error("Read arrived while the request queue was full");
        fail_count++;
    end

    // Accelerator responses pass through one cycle later
    afu_forward: assert property (@(posedge clk) disable iff (reset)
        afu_rsp_valid |=> rsp_valid && (rsp_tid == $past(afu_rsp_tid)))
    else
    begin
        $error("Accelerator response not forwarded");
        fail_count++;
    end

endmodule

bind csr_manager csr_manager_assertions u_assertions (
    .clk, .reset,
    .xlate_enable, .xlate_inval, .pt_base_valid,
    .rsp_valid, .rsp_tid, .afu_rsp_valid, .afu_rsp_tid,
    .flush(u_accum.flush),
    .req_op(u_decode.req_op),
    .queue_full(u_decode.full)
);

//--- sim/csr_manager_tb.sv
// Register manager testbench
`timescale 1ns/1ps

module csr_manager_tb
    import csr_pkg::*;
();

    // ==============================
    // Run settings
    // ==============================

    localparam int unsigned SEED = 32'h8e27;
    // Two event phases near 2500 cycles each plus reads, with wide margin
    localparam int MAX_CYCLES = 20000;
    localparam int RSP_WAIT = 400;
    // Covers two flush intervals and the update sequence
    localparam int SETTLE_CYCLES = 2300;
    localparam logic [15:0] BASE_UNIT = CSR_BASE_ADDR[17:2];
    // Header fields: type, end of list, next offset, instance
    localparam t_csr_data DFH_EXPECT =
        (64'h2 << 60) | (64'h1 << 40) | (64'h80 << 16) | 64'h1;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   mmio_valid;
    logic                   mmio_write;
    logic [MMIO_ADDR_W-1:0] mmio_addr;
    t_tid                   mmio_tid;
    t_csr_data              mmio_data;
    logic                   rsp_valid;
    t_tid                   rsp_tid;
    t_csr_data              rsp_data;
    logic                   afu_rsp_valid;
    t_tid                   afu_rsp_tid;
    t_csr_data              afu_rsp_data;
    logic                   event_hit;
    logic                   event_miss;
    logic                   event_walk_busy;
    logic                   xlate_enable;
    logic                   xlate_inval;
    logic [PT_BASE_W-1:0]   pt_base;
    logic                   pt_base_valid;

    // Reference model state
    logic      pending [1 << TID_W];
    t_csr_data exp_data [1 << TID_W];
    int        exp_cnt [NUM_STATS];
    int        outstanding = 0;
    t_tid      next_tid = '0;
    // Accelerator response of the previous cycle
    logic      prev_afu_valid = 1'b0;
    t_tid      prev_afu_tid;
    t_csr_data prev_afu_data;
    int        cycles = 0;

    always #10 clk = ~clk;

    csr_manager UUT (
        .clk, .reset,
        .mmio_valid, .mmio_write, .mmio_addr, .mmio_tid, .mmio_data,
        .rsp_valid, .rsp_tid, .rsp_data,
        .afu_rsp_valid, .afu_rsp_tid, .afu_rsp_data,
        .event_hit, .event_miss, .event_walk_busy,
        .xlate_enable, .xlate_inval, .pt_base, .pt_base_valid
    );

    task automatic value_error(input string test, input t_csr_data expected,
                               input t_csr_data actual);
        $display("FAILED %s expected %h actual %h", test, expected, actual);
        $display("TESTS FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic plain_error(input string what);
        $display("ERROR: %s", what);
        $display("TESTS FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    // Expected contents of each word
    function automatic t_csr_data model_word(input int word);
        case (word)
            0: return DFH_EXPECT;
            1: return FEATURE_UID[63:0];
            2: return FEATURE_UID[127:64];
            4, 5, 6: return t_csr_data'(exp_cnt[word - 4]);
            default: return '0;
        endcase
    endfunction

    function automatic void host_idle();
        mmio_valid = 1'b0;
        mmio_write = 1'b0;
    endfunction

    // Puts a read on the bus and books its response
    function automatic void present_read(input int word);
        mmio_valid = 1'b1;
        mmio_write = 1'b0;
        mmio_addr = BASE_UNIT + 16'(2 * word);
        mmio_tid = next_tid;
        pending[next_tid] = 1'b1;
        exp_data[next_tid] = model_word(word);
        outstanding++;
        // Local tags keep the top bit clear
        next_tid = {1'b0, next_tid[7:0] + 8'd1};
    endfunction

    task automatic read_word(input int word);
        while (outstanding >= REQ_QUEUE_DEPTH)
            @(negedge clk);
        @(negedge clk);
        present_read(word);
        @(negedge clk);
        host_idle();
    endtask

    task automatic write_word(input int word, input t_csr_data data);
        @(negedge clk);
        mmio_valid = 1'b1;
        mmio_write = 1'b1;
        mmio_addr = BASE_UNIT + 16'(2 * word);
        mmio_data = data;
        @(negedge clk);
        host_idle();
    endtask

    task automatic wait_responses();
        int waited;
        waited = 0;
        while (outstanding != 0)
        begin
            @(negedge clk);
            waited++;
            if (waited > RSP_WAIT)
                plain_error("a read response never arrived");
        end
    endtask

    // Mode write, then check the two-cycle update and the pulse
    task automatic check_mode_write(input logic [1:0] bits);
        logic old_enable;
        old_enable = xlate_enable;
        write_word(int'(IDX_MODE), {62'($urandom), bits});
        @(negedge clk);
        assert (xlate_enable == old_enable)
        else value_error("mode_enable_hold", old_enable, xlate_enable);
        assert (!xlate_inval) else value_error("mode_inval_early", 0, xlate_inval);
        @(negedge clk);
        assert (xlate_enable == bits[0]) else value_error("mode_enable", bits[0], xlate_enable);
        assert (xlate_inval == bits[1]) else value_error("mode_inval", bits[1], xlate_inval);
        @(negedge clk);
        assert (!xlate_inval) else value_error("mode_inval_end", 0, xlate_inval);
    endtask

    task automatic drive_events(input int n);
        logic [2:0] ev;
        for (int c = 0; c < n; c++)
        begin
            @(negedge clk);
            ev = 3'($urandom);
            event_hit = ev[0];
            event_miss = ev[1];
            event_walk_busy = ev[2];
            for (int s = 0; s < NUM_STATS; s++)
                exp_cnt[s] += int'(ev[s]);
        end
        @(negedge clk);
        event_hit = 1'b0;
        event_miss = 1'b0;
        event_walk_busy = 1'b0;
    endtask

    task automatic check_stats();
        repeat (SETTLE_CYCLES) @(negedge clk);
        for (int w = 4; w <= 6; w++)
            read_word(w);
        wait_responses();
    endtask

    // A read outside the region must stay unanswered
    task automatic stray_read(input logic [MMIO_ADDR_W-1:0] addr);
        @(negedge clk);
        mmio_valid = 1'b1;
        mmio_write = 1'b0;
        mmio_addr = addr;
        mmio_tid = next_tid;
        next_tid = {1'b0, next_tid[7:0] + 8'd1};
        @(negedge clk);
        host_idle();
        repeat (100) @(negedge clk);
    endtask

    // ==============================
    // Response monitor
    // ==============================

    always @(posedge clk)
    begin
        if (!reset)
        begin
            if (prev_afu_valid)
            begin
                assert (rsp_valid) else plain_error("accelerator response was dropped");
                assert (rsp_tid == prev_afu_tid)
                else value_error("afu_pass_tid", prev_afu_tid, rsp_tid);
                assert (rsp_data == prev_afu_data)
                else value_error("afu_pass_data", prev_afu_data, rsp_data);
            end
            else if (rsp_valid)
            begin
                assert (pending[rsp_tid])
                else plain_error($sformatf("response tag %0h has no outstanding read", rsp_tid));
                assert (rsp_data == exp_data[rsp_tid])
                else value_error($sformatf("read_tag_%0h", rsp_tid), exp_data[rsp_tid], rsp_data);
                pending[rsp_tid] = 1'b0;
                outstanding--;
            end
        end
        prev_afu_valid = afu_rsp_valid;
        prev_afu_tid = afu_rsp_tid;
        prev_afu_data = afu_rsp_data;
    end

    // Watchdog and bound assertion status
    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
            plain_error("run exceeded the cycle limit");
        if (UUT.u_assertions.fail_count != 0)
            plain_error("a bound protocol assertion failed");
    end

    // ==============================
    // Stimulus
    // ==============================

    initial
    begin
        t_csr_data   pt_val;
        void'($urandom(SEED));
        reset = 1'b1;
        host_idle();
        mmio_addr = '0;
        mmio_tid = '0;
        mmio_data = '0;
        afu_rsp_valid = 1'b0;
        afu_rsp_tid = '0;
        afu_rsp_data = '0;
        event_hit = 1'b0;
        event_miss = 1'b0;
        event_walk_busy = 1'b0;
        for (int t = 0; t < (1 << TID_W); t++)
            pending[t] = 1'b0;
        for (int s = 0; s < NUM_STATS; s++)
            exp_cnt[s] = 0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        // Store fills one word per cycle
        repeat (CSR_WORDS + 2) @(negedge clk);

        // Header, ID and zero words
        read_word(0);
        read_word(1);
        read_word(2);
        read_word(9);
        read_word(int'(IDX_MODE));
        wait_responses();

        // Mode control
        check_mode_write(2'b11);
        check_mode_write(2'b00);

        // Page table base
        pt_val = {$urandom, $urandom};
        write_word(int'(IDX_PT_BASE), pt_val);
        repeat (2) @(negedge clk);
        assert (pt_base == pt_val[PT_BASE_W-1:0])
        else value_error("pt_base", pt_val[PT_BASE_W-1:0], pt_base);
        assert (pt_base_valid) else value_error("pt_base_valid", 1, pt_base_valid);

        // Statistics, second batch adds to the first
        drive_events(50 + int'($urandom % 150));
        check_stats();
        drive_events(50 + int'($urandom % 150));
        check_stats();

        // Local reads mixed with accelerator traffic
        for (int c = 0; c < 40; c++)
        begin
            @(negedge clk);
            afu_rsp_valid = 1'($urandom);
            afu_rsp_tid = {1'b1, 8'($urandom)};
            afu_rsp_data = {$urandom, $urandom};
            if (c % 3 == 0 && outstanding < REQ_QUEUE_DEPTH)
                present_read(int'($urandom % CSR_WORDS));
            else
                host_idle();
        end
        @(negedge clk);
        afu_rsp_valid = 1'b0;
        host_idle();
        wait_responses();

        // Below and just above the region
        stray_read(BASE_UNIT - 16'd2);
        stray_read(BASE_UNIT + 16'(2 * CSR_WORDS));

        if (UUT.u_assertions.fail_count == 0)
        begin
            $display("TESTS PASSED");
            $finish;
        end
        else
        begin
            $display("TESTS FAILED");
            $fatal(1, "Bound protocol assertion failed");
        end
    end

endmodule

//--- build.f
design/csr_pkg.sv
design/mmio_decode.sv
design/event_accum.sv
design/csr_access.sv
design/csr_store.sv
design/read_response.sv
design/csr_manager.sv
sim/csr_manager_assertions.sv
sim/csr_manager_tb.sv

//--- Bender.yml
package:
  name: csr_manager

sources:
  - files:
      - design/csr_pkg.sv
      - design/mmio_decode.sv
      - design/event_accum.sv
      - design/csr_access.sv
      - design/csr_store.sv
      - design/read_response.sv
      - design/csr_manager.sv
  - target: simulation
    files:
      - sim/csr_manager_assertions.sv
      - sim/csr_manager_tb.sv
